// File: vlog.f
+incdir+.
pgwr_tbl_pkg.sv
pgwr_axi_pkg.sv
pgwr_stage_if.sv
pgwr_entry_seq.sv
pgwr_line_packer.sv
pgwr_axi_issue.sv
pgwr_mngr_top.sv
tb_pgwr_mngr.sv

// File: Bender.yml
package:
  name: pgwr_mngr

export_include_dirs:
  - .

sources:
  - pgwr_tbl_pkg.sv
  - pgwr_axi_pkg.sv
  - pgwr_stage_if.sv
  - pgwr_entry_seq.sv
  - pgwr_line_packer.sv
  - pgwr_axi_issue.sv
  - pgwr_mngr_top.sv
  - target: test
    files:
      - tb_pgwr_mngr.sv

// File: tb_pgwr_mngr.sv
/*
 * testbench for the page-write manager table initializer
 * random AXI slave and in-order reference model of every table write
 */
`timescale 1ns/1ps
`include "pgwr_settings.svh"

module tb_pgwr_mngr;
	import pgwr_axi_pkg::*;

	localparam int ATT_CNT     = `PGWR_ATT_ENTRY_CNT;
	localparam int LIST_CNT    = `PGWR_LIST_ENTRY_CNT;
	localparam int WORST_STALL = 24;  // AW/W stalls plus response gap per write
	localparam int TIMEOUT_CYC = 5 * (ATT_CNT + LIST_CNT) * WORST_STALL + 2000;

	logic      clk_i;
	logic      rst_ni;
	logic      init_att;
	logic      init_list;
	logic      awvalid;
	logic      awready;
	axi_addr_t awaddr;
	logic      wvalid;
	logic      wready;
	line_t     wdata;
	strb_t     wstrb;
	logic      bvalid;
	bresp_t    bresp;
	logic      att_done;
	logic      list_done;
	logic      bus_error;

	integer    seed = 32'h84d29220;
	int        cyc_cnt = 0;
	int        err_cnt = 0;
	int        test_err0;
	int        n_pass = 0;
	int        n_fail = 0;
	int        write_cnt;   // writes with both AW and W seen
	int        pend_resp;   // completed writes not yet answered
	int        resp_sent;
	int        resp_wait;
	bit        inject_err = 0;
	bit        inject_bvalid = 0;
	bit        aw_stall;
	bit        w_stall;
	axi_addr_t aw_hold;
	line_t     w_hold;

	axi_addr_t exp_addr_q[$];  // reference model in issue order
	line_t     exp_data_q[$];
	strb_t     exp_strb_q[$];
	axi_addr_t aw_q[$];        // accepted but not yet paired
	line_t     wd_q[$];
	strb_t     ws_q[$];

	pgwr_mngr_top DUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// ends a hung run
	always @(posedge clk_i) begin
		cyc_cnt++;
		if (cyc_cnt >= TIMEOUT_CYC) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Some tests failed");
			$finish;
		end
	end

	// expected write for ATT entry n with 8 entries per line
	task automatic push_att(input int n);
		int          slot;
		logic [63:0] ent;
		line_t       d;
		strb_t       s;
		slot = (n - 1) % 8;
		ent  = '0;
		if (`PGWR_PWRUP_UNCOMP && n <= LIST_CNT) begin
			ent[1:0]  = 2'd1;  // STS_UNCOMP
			ent[41:2] = `PGWR_PPA_BASE + 40'(n - 1);
		end
		d = '0;
		d[slot*64 +: 64] = ent;
		s = '0;
		for (int b = 0; b < 8; b++)
			s[slot*8 + b] = 1'b1;
		exp_addr_q.push_back(`PGWR_ATT_BASE + 32'(64 * ((n - 1) / 8)));
		exp_data_q.push_back(d);
		exp_strb_q.push_back(s);
	endtask

	// expected write for list entry n in the chain 1 <-> 2 <-> .. <-> LIST_CNT
	task automatic push_list(input int n);
		int           slot;
		logic [127:0] ent;
		line_t        d;
		strb_t        s;
		slot = (n - 1) % 4;
		ent  = '0;
		ent[23:0]   = (n == LIST_CNT) ? 24'd0 : 24'(n + 1);  // null next on the tail
		ent[47:24]  = 24'(n - 1);                            // null prev on the head
		ent[111:72] = `PGWR_PPA_BASE + 40'(n - 1);
		d = '0;
		d[slot*128 +: 128] = ent;
		s = '0;
		for (int b = 0; b < 16; b++)
			s[slot*16 + b] = 1'b1;
		exp_addr_q.push_back(`PGWR_LIST_BASE + 32'(64 * ((n - 1) / 4)));
		exp_data_q.push_back(d);
		exp_strb_q.push_back(s);
	endtask

	// compare one finished write with the head of the model queue
	task automatic check_write(input axi_addr_t a, input line_t d, input strb_t s);
		axi_addr_t ea;
		line_t     ed;
		strb_t     es;
		write_cnt++;
		pend_resp++;
		if (exp_addr_q.size() == 0) begin
			$display("unexpected write to %h at %0t, no write was due", a, $time);
			err_cnt++;
		end else begin
			ea = exp_addr_q.pop_front();
			ed = exp_data_q.pop_front();
			es = exp_strb_q.pop_front();
			if (a !== ea) begin
				$display("mismatch at %0t: awaddr got %h expected %h", $time, a, ea);
				err_cnt++;
			end
			if (d !== ed) begin
				$display("mismatch at %0t: wdata got %h expected %h", $time, d, ed);
				err_cnt++;
			end
			if (s !== es) begin
				$display("mismatch at %0t: wstrb got %h expected %h", $time, s, es);
				err_cnt++;
			end
		end
	endtask

	// bus monitor sampling at the edge where handshakes happen
	always @(posedge clk_i) begin
		if (!rst_ni) begin
			aw_q.delete();
			wd_q.delete();
			ws_q.delete();
			write_cnt = 0;
			aw_stall  = 0;
			w_stall   = 0;
		end else begin
			if (aw_stall && (!awvalid || awaddr !== aw_hold)) begin
				$display("mismatch at %0t: awaddr got %h expected %h while stalled", $time,
					awaddr, aw_hold);
				err_cnt++;
			end
			if (w_stall && (!wvalid || wdata !== w_hold)) begin
				$display("mismatch at %0t: wdata got %h expected %h while stalled", $time,
					wdata, w_hold);
				err_cnt++;
			end
			aw_stall = awvalid && !awready;
			aw_hold  = awaddr;
			w_stall  = wvalid && !wready;
			w_hold   = wdata;
			if (awvalid && awready)
				aw_q.push_back(awaddr);
			if (wvalid && wready) begin
				wd_q.push_back(wdata);
				ws_q.push_back(wstrb);
			end
			while (aw_q.size() > 0 && wd_q.size() > 0)
				check_write(aw_q.pop_front(), wd_q.pop_front(), ws_q.pop_front());
		end
	end

	// slave model with random ready and in-order responses after a random gap
	always @(negedge clk_i) begin
		if (!rst_ni) begin
			awready   = 1'b0;
			wready    = 1'b0;
			bvalid    = 1'b0;
			bresp     = 2'b00;
			pend_resp = 0;
			resp_sent = 0;
			resp_wait = 0;
		end else begin
			awready = ($random(seed) & 3) != 0;  // ready 3 cycles in 4
			wready  = ($random(seed) & 3) != 0;
			bvalid  = 1'b0;
			bresp   = 2'b00;
			if (inject_bvalid) begin
				bvalid        = 1'b1;  // nobody is waiting for this one
				inject_bvalid = 0;
			end else if (pend_resp > 0) begin
				if (resp_wait == 0) begin
					bvalid = 1'b1;
					if (inject_err) begin
						bresp      = 2'b10;  // SLVERR
						inject_err = 0;
					end
					pend_resp--;
					resp_sent++;
					resp_wait = $unsigned($random(seed)) % 6;
				end else begin
					resp_wait--;
				end
			end
		end
	end

	task automatic apply_reset();
		@(negedge clk_i);
		rst_ni    = 1'b0;
		init_att  = 1'b0;
		init_list = 1'b0;
		exp_addr_q.delete();
		exp_data_q.delete();
		exp_strb_q.delete();
		repeat (16) @(negedge clk_i);
		rst_ni = 1'b1;
	endtask

	// one-cycle request pulse
	task automatic request(input logic att, input logic lst);
		@(negedge clk_i);
		init_att  = att;
		init_list = lst;
		@(negedge clk_i);
		init_att  = 1'b0;
		init_list = 1'b0;
	endtask

	// request levels that stay until driven again
	task automatic hold_requests(input logic att, input logic lst);
		@(negedge clk_i);
		init_att  = att;
		init_list = lst;
	endtask

	// done must not come before all responses of the table are back
	task automatic wait_for_done(input bit list_sel, input int need_resp);
		do
			@(posedge clk_i);
		while (!(list_sel ? list_done : att_done));
		if (resp_sent < need_resp) begin
			$display("done flag rose at %0t after %0d of %0d responses", $time, resp_sent,
				need_resp);
			err_cnt++;
		end
		repeat (4) @(posedge clk_i);
		if (exp_addr_q.size() != 0) begin
			$display("%0d expected writes never arrived", exp_addr_q.size());
			err_cnt++;
		end
	endtask

	task automatic check_no_error();
		if (bus_error !== 1'b0) begin
			$display("mismatch at %0t: bus_error got %b expected 0", $time, bus_error);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		if (err_cnt == test_err0) begin
			n_pass++;
			$display("test %s: pass", name);
		end else begin
			n_fail++;
			$display("test %s: FAIL with %0d errors", name, err_cnt - test_err0);
		end
	endtask

	initial begin
		rst_ni    = 1'b0;
		init_att  = 1'b0;
		init_list = 1'b0;
		awready   = 1'b0;
		wready    = 1'b0;
		bvalid    = 1'b0;
		bresp     = 2'b00;
		apply_reset();

		// quiet bus and clear flags with no request
		test_err0 = err_cnt;
		repeat (20) begin
			@(posedge clk_i);
			if ({awvalid, wvalid, att_done, list_done, bus_error} !== 5'b0) begin
				$display("mismatch at %0t: %s got %b expected 00000", $time,
					"{awvalid,wvalid,att_done,list_done,bus_error}",
					{awvalid, wvalid, att_done, list_done, bus_error});
				err_cnt++;
			end
		end
		end_test("idle after reset");

		// ATT fill
		test_err0 = err_cnt;
		for (int n = 1; n <= ATT_CNT; n++)
			push_att(n);
		request(1'b1, 1'b0);
		wait_for_done(1'b0, ATT_CNT);
		if (write_cnt != ATT_CNT) begin
			$display("mismatch at %0t: write count got %0d expected %0d", $time, write_cnt,
				ATT_CNT);
			err_cnt++;
		end
		if (list_done !== 1'b0) begin
			$display("mismatch at %0t: list_done got %b expected 0", $time, list_done);
			err_cnt++;
		end
		check_no_error();
		end_test("att init");

		// list fill after the ATT in the same run
		test_err0 = err_cnt;
		for (int n = 1; n <= LIST_CNT; n++)
			push_list(n);
		request(1'b0, 1'b1);
		wait_for_done(1'b1, ATT_CNT + LIST_CNT);
		if (write_cnt != ATT_CNT + LIST_CNT) begin
			$display("mismatch at %0t: write count got %0d expected %0d", $time, write_cnt,
				ATT_CNT + LIST_CNT);
			err_cnt++;
		end
		check_no_error();
		end_test("list init");

		// both held high together with all ATT writes expected before all list writes
		apply_reset();
		test_err0 = err_cnt;
		for (int n = 1; n <= ATT_CNT; n++)
			push_att(n);
		for (int n = 1; n <= LIST_CNT; n++)
			push_list(n);
		hold_requests(1'b1, 1'b1);
		wait_for_done(1'b1, ATT_CNT + LIST_CNT);
		hold_requests(1'b0, 1'b0);
		if (att_done !== 1'b1) begin
			$display("mismatch at %0t: att_done got %b expected 1", $time, att_done);
			err_cnt++;
		end
		request(1'b1, 1'b1);  // tables are filled once per reset
		repeat (40) @(posedge clk_i);
		if (write_cnt != ATT_CNT + LIST_CNT) begin
			$display("mismatch at %0t: write count got %0d expected %0d", $time, write_cnt,
				ATT_CNT + LIST_CNT);
			err_cnt++;
		end
		check_no_error();
		end_test("joint init under back-pressure");

		// error response and then an unsolicited response in a fresh run
		apply_reset();
		test_err0 = err_cnt;
		@(posedge clk_i);
		inject_err = 1;
		for (int n = 1; n <= ATT_CNT; n++)
			push_att(n);
		request(1'b1, 1'b0);
		wait_for_done(1'b0, ATT_CNT);
		if (bus_error !== 1'b1) begin
			$display("mismatch at %0t: bus_error got %b expected 1 after SLVERR", $time,
				bus_error);
			err_cnt++;
		end
		apply_reset();
		repeat (4) @(posedge clk_i);
		check_no_error();
		inject_bvalid = 1;
		repeat (4) @(posedge clk_i);
		if (bus_error !== 1'b1) begin
			$display("mismatch at %0t: bus_error got %b expected 1 after stray bvalid", $time,
				bus_error);
			err_cnt++;
		end
		end_test("bus error");

		$display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, err_cnt);
		if (n_fail == 0 && err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: pgwr_mngr_top.sv
/*
 * page-write manager table initializer, top level
 * sequencer -> line packer -> AXI issue, plain AXI write ports
 */
`timescale 1ns/1ps

module pgwr_mngr_top (
	input  logic                    clk_i,
	input  logic                    rst_ni,

	// init requests
	input  logic                    init_att,
	input  logic                    init_list,

	// AXI write address
	output logic                    awvalid,
	input  logic                    awready,
	output pgwr_axi_pkg::axi_addr_t awaddr,

	// AXI write data, single beat
	output logic                    wvalid,
	input  logic                    wready,
	output pgwr_axi_pkg::line_t     wdata,
	output pgwr_axi_pkg::strb_t     wstrb,

	// AXI write response, always accepted
	input  logic                    bvalid,
	input  pgwr_axi_pkg::bresp_t    bresp,

	// status
	output logic                    att_done,
	output logic                    list_done,
	output logic                    bus_error
);

	entry_if entry_link ();  // seq -> packer
	line_if  line_link ();   // packer -> issue

	pgwr_entry_seq u_entry_seq (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.init_att  (init_att),
		.init_list (init_list),
		.out       (entry_link.driver)
	);

	pgwr_line_packer u_line_packer (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.in     (entry_link.receiver),
		.out    (line_link.driver)
	);

	pgwr_axi_issue u_axi_issue (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.in        (line_link.receiver),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.att_done  (att_done),
		.list_done (list_done),
		.bus_error (bus_error)
	);

endmodule

// File: pgwr_axi_issue.sv
/*
 * AXI write issue, one line at a time on AW and W
 * counts in-order responses per table, raises done and bus error
 */
`timescale 1ns/1ps

module pgwr_axi_issue (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	line_if.receiver               in,
	output logic                   awvalid,
	input  logic                   awready,
	output pgwr_axi_pkg::axi_addr_t awaddr,
	output logic                   wvalid,
	input  logic                   wready,
	output pgwr_axi_pkg::line_t    wdata,
	output pgwr_axi_pkg::strb_t    wstrb,
	input  logic                   bvalid,
	input  pgwr_axi_pkg::bresp_t   bresp,
	output logic                   att_done,
	output logic                   list_done,
	output logic                   bus_error
);
	import pgwr_tbl_pkg::*;
	import pgwr_axi_pkg::*;

	logic             aw_pend_q;   // AW not yet taken
	logic             w_pend_q;    // W not yet taken
	init_kind_e       kind_q;
	logic             last_q;
	axi_addr_t        addr_q;
	line_t            data_q;
	strb_t            strb_q;
	logic             take;
	logic             aw_fire;
	logic             w_fire;
	logic [1:0]       inc;         // indexed by init_kind_e
	logic [1:0]       dec;
	entry_idx_t [1:0] cnt_q;       // writes awaiting a response
	logic [1:0]       last_seen_q; // last line of the kind issued
	logic [1:0]       done_q;

	// next line only once both channels are through
	assign in.ready = !aw_pend_q && !w_pend_q;
	assign take     = in.valid && in.ready;
	assign aw_fire  = awvalid && awready;
	assign w_fire   = wvalid && wready;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
		end else if (take) begin
			aw_pend_q <= 1'b1;
			w_pend_q  <= 1'b1;
		end else begin
			if (aw_fire) aw_pend_q <= 1'b0; // channels drop on their own
			if (w_fire)  w_pend_q  <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			kind_q <= in.kind;
			last_q <= in.last;
			addr_q <= in.addr;
			data_q <= in.data;
			strb_q <= in.strb;
		end
	end

	assign awvalid = aw_pend_q;
	assign awaddr  = addr_q;
	assign wvalid  = w_pend_q;
	assign wdata   = data_q;
	assign wstrb   = strb_q;

	// responses are in order and ATT writes go out first,
	// so a response belongs to ATT while ATT still has writes open
	assign inc[KIND_ATT]  = aw_fire && (kind_q == KIND_ATT);
	assign inc[KIND_LIST] = aw_fire && (kind_q == KIND_LIST);
	assign dec[KIND_ATT]  = bvalid && (cnt_q[KIND_ATT] != '0);
	assign dec[KIND_LIST] = bvalid && (cnt_q[KIND_ATT] == '0) && (cnt_q[KIND_LIST] != '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q       <= '0;
			last_seen_q <= '0;
			done_q      <= '0;
			bus_error   <= 1'b0;
		end else begin
			for (int k = 0; k < 2; k++) begin
				if (inc[k] && !dec[k])
					cnt_q[k] <= cnt_q[k] + entry_idx_t'(1);
				else if (dec[k] && !inc[k])
					cnt_q[k] <= cnt_q[k] - entry_idx_t'(1);
				if (inc[k] && last_q)
					last_seen_q[k] <= 1'b1;
				if (last_seen_q[k] && cnt_q[k] == '0)
					done_q[k] <= 1'b1; // sticky
			end
			// error response, or a response nobody is waiting for
			if (bvalid && (bresp != BRESP_OKAY || cnt_q == '0))
				bus_error <= 1'b1;
		end
	end

	assign att_done  = done_q[KIND_ATT];
	assign list_done = done_q[KIND_LIST];

	// AXI hold rule on both request channels
	a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(awaddr));
	a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

// File: pgwr_line_packer.sv
/*
 * line packer, turns an entry index into a line write
 * builds address, entry data in its slot and the slot's strobe
 */
`timescale 1ns/1ps
`include "pgwr_settings.svh"

module pgwr_line_packer (
	input  logic      clk_i,
	input  logic      rst_ni,
	entry_if.receiver in,
	line_if.driver    out
);
	import pgwr_tbl_pkg::*;
	import pgwr_axi_pkg::*;

	localparam entry_idx_t LIST_CNT     = entry_idx_t'(`PGWR_LIST_ENTRY_CNT);
	localparam axi_addr_t  ATT_BASE     = `PGWR_ATT_BASE;
	localparam axi_addr_t  LIST_BASE    = `PGWR_LIST_BASE;
	localparam ppa_t       PPA_BASE     = `PGWR_PPA_BASE;
	localparam bit         PWRUP_UNCOMP = `PGWR_PWRUP_UNCOMP;

	entry_idx_t  ofs;      // zero-based entry number
	ppa_t        way;
	logic [2:0]  att_slot; // 8 ATT entries per line
	logic [1:0]  lst_slot; // 4 list entries per line
	att_entry_t  att_e;
	list_entry_t lst_e;
	axi_addr_t   addr_d;
	line_t       data_d;
	strb_t       strb_d;
	logic        take;

	// single slot
	logic        vld_q;
	init_kind_e  kind_q;
	logic        last_q;
	axi_addr_t   addr_q;
	line_t       data_q;
	strb_t       strb_q;

	assign ofs      = in.idx - entry_idx_t'(1);
	assign way      = PPA_BASE + ppa_t'(ofs); // one page per entry
	assign att_slot = ofs[2:0];
	assign lst_slot = ofs[1:0];

	always_comb begin
		att_e.zpd_cnt = '0;
		if (PWRUP_UNCOMP && in.idx <= LIST_CNT) begin
			att_e.sts = STS_UNCOMP; // backed by the matching list way
			att_e.way = way;
		end else begin
			att_e.sts = STS_DALLOC;
			att_e.way = '0;
		end
	end

	// one long doubly linked free list, head 1 and tail LIST_CNT
	always_comb begin
		lst_e.rsvd   = '0;
		lst_e.way    = way;
		lst_e.att_id = '0;            // free, no owner yet
		lst_e.prev   = ofs;           // 0 on the head
		lst_e.next   = in.last ? '0 : in.idx + entry_idx_t'(1);
	end

	always_comb begin
		if (in.kind == KIND_ATT) begin
			addr_d = ATT_BASE + (axi_addr_t'(ofs >> 3) << 6);
			data_d = line_t'(att_e) << {att_slot, 6'd0};      // 64 bits per slot
			strb_d = strb_t'(8'hff) << {att_slot, 3'd0};
		end else begin
			addr_d = LIST_BASE + (axi_addr_t'(ofs >> 2) << 6);
			data_d = line_t'(lst_e) << {lst_slot, 7'd0};      // 128 bits per slot
			strb_d = strb_t'(16'hffff) << {lst_slot, 4'd0};
		end
	end

	// free slot or one that leaves this cycle
	assign in.ready = !vld_q || out.ready;
	assign take     = in.valid && in.ready;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			vld_q <= 1'b0;
		end else if (take) begin
			vld_q <= 1'b1;
		end else if (out.ready) begin
			vld_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			kind_q <= in.kind;
			last_q <= in.last;
			addr_q <= addr_d;
			data_q <= data_d;
			strb_q <= strb_d;
		end
	end

	assign out.valid = vld_q;
	assign out.kind  = kind_q;
	assign out.last  = last_q;
	assign out.addr  = addr_q;
	assign out.data  = data_q;
	assign out.strb  = strb_q;

endmodule

// File: pgwr_entry_seq.sv
/*
 * entry sequencer, picks the init mode and walks the table
 * emits idx 1..N per table, ATT first, each table once
 */
`timescale 1ns/1ps
`include "pgwr_settings.svh"

module pgwr_entry_seq (
	input  logic    clk_i,
	input  logic    rst_ni,
	input  logic    init_att,
	input  logic    init_list,
	entry_if.driver out
);
	import pgwr_tbl_pkg::*;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ATT,
		SEQ_LIST
	} seq_state_e;

	localparam entry_idx_t ATT_CNT  = entry_idx_t'(`PGWR_ATT_ENTRY_CNT);
	localparam entry_idx_t LIST_CNT = entry_idx_t'(`PGWR_LIST_ENTRY_CNT);

	seq_state_e state_q, state_d;
	entry_idx_t idx_q, idx_d;
	entry_idx_t cur_cnt;       // size of the table being walked
	logic       att_issued_q;  // ATT fill already started
	logic       list_issued_q;
	logic       fire;

	assign cur_cnt = (state_q == SEQ_LIST) ? LIST_CNT : ATT_CNT;
	assign fire    = out.valid && out.ready;

	// outputs straight from state, so they hold under back-pressure
	assign out.valid = (state_q != SEQ_IDLE);
	assign out.kind  = (state_q == SEQ_LIST) ? KIND_LIST : KIND_ATT;
	assign out.idx   = idx_q;
	assign out.last  = (idx_q == cur_cnt);

	always_comb begin
		state_d = state_q;
		idx_d   = idx_q;
		case (state_q)
			SEQ_IDLE: begin
				// ATT wins when both are asked for
				if (init_att && !att_issued_q) begin
					state_d = SEQ_ATT;
					idx_d   = entry_idx_t'(1);
				end else if (init_list && !list_issued_q) begin
					state_d = SEQ_LIST;
					idx_d   = entry_idx_t'(1);
				end
			end
			SEQ_ATT, SEQ_LIST: begin
				if (fire) begin
					if (out.last) begin
						state_d = SEQ_IDLE; // table done, list may follow
					end else begin
						idx_d = idx_q + entry_idx_t'(1);
					end
				end
			end
			default: state_d = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q       <= SEQ_IDLE;
			idx_q         <= '0;
			att_issued_q  <= 1'b0;
			list_issued_q <= 1'b0;
		end else begin
			state_q <= state_d;
			idx_q   <= idx_d;
			// sticky, a second request on a filled table is ignored
			if (state_q == SEQ_IDLE && state_d == SEQ_ATT)
				att_issued_q <= 1'b1;
			if (state_q == SEQ_IDLE && state_d == SEQ_LIST)
				list_issued_q <= 1'b1;
		end
	end

	// offered index is always a live entry of the current table
	a_idx_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out.valid |-> (out.idx != '0) && (out.idx <= cur_cnt));

endmodule

// File: pgwr_stage_if.sv
/*
 * stage links of the table initializer
 * entry_if carries entry indices, line_if carries packed write lines
 */
`timescale 1ns/1ps

interface entry_if;
	import pgwr_tbl_pkg::*;

	logic       valid;
	logic       ready;
	init_kind_e kind;  // target table
	entry_idx_t idx;   // 1-based
	logic       last;  // final entry of the table

	modport driver (output valid, kind, idx, last, input ready);
	modport receiver (input valid, kind, idx, last, output ready);
endinterface

interface line_if;
	import pgwr_tbl_pkg::*;
	import pgwr_axi_pkg::*;

	logic       valid;
	logic       ready;
	init_kind_e kind;
	logic       last;
	axi_addr_t  addr;  // line aligned
	line_t      data;
	strb_t      strb;  // only the entry's bytes

	modport driver (output valid, kind, last, addr, data, strb, input ready);
	modport receiver (input valid, kind, last, addr, data, strb, output ready);
endinterface

// File: pgwr_axi_pkg.sv
/*
 * AXI write types of the page-write manager
 * one full 64-byte line per write, single beat
 */
`include "pgwr_settings.svh"

package pgwr_axi_pkg;

	// byte address
	typedef logic [31:0] axi_addr_t;

	// one cache line of write data
	typedef logic [511:0] line_t;

	// byte enables for one line
	typedef logic [63:0] strb_t;

	// write response code
	typedef logic [1:0] bresp_t;

	// anything else is a bus error
	localparam bresp_t BRESP_OKAY = 2'b00;

	// bytes per line, ties line_t and strb_t together
	localparam int unsigned LINE_BYTES = $bits(strb_t);

endpackage

// File: pgwr_tbl_pkg.sv
/*
 * table types of the page-write manager
 * entry index, ATT and list entry layouts, status and init kind
 */
`include "pgwr_settings.svh"

package pgwr_tbl_pkg;

	// 1-based index, 0 means null
	typedef logic [`PGWR_IDX_W-1:0] entry_idx_t;

	// physical page number
	typedef logic [39:0] ppa_t;

	// ATT entry status
	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0, // not backed by a page
		STS_UNCOMP = 2'd1, // page holds raw data
		STS_COMP   = 2'd2  // page lives in a zspage
	} att_sts_e;

	// which table an entry belongs to
	typedef enum logic {
		KIND_ATT  = 1'b0,
		KIND_LIST = 1'b1
	} init_kind_e;

	// 8-byte ATT entry, 8 per line
	typedef struct packed {
		logic [21:0] zpd_cnt; // [63:42]
		ppa_t        way;     // [41:2]
		att_sts_e    sts;     // [1:0]
	} att_entry_t;

	// 16-byte list entry, 4 per line
	typedef struct packed {
		logic [15:0] rsvd;   // [127:112]
		ppa_t        way;    // [111:72]
		entry_idx_t  att_id; // [71:48] owning ATT entry
		entry_idx_t  prev;   // [47:24]
		entry_idx_t  next;   // [23:0]
	} list_entry_t;

endpackage

// File: pgwr_settings.svh
/*
 * page-write manager table init settings
 * sizes and base addresses of the ATT and list tables, power-up option
 */
`ifndef PGWR_SETTINGS_SVH
`define PGWR_SETTINGS_SVH

// table sizes in entries
`define PGWR_ATT_ENTRY_CNT  16
`define PGWR_LIST_ENTRY_CNT 8

// byte base of each table in memory, 64-byte aligned
`define PGWR_ATT_BASE  32'h0000_1000
`define PGWR_LIST_BASE 32'h0000_2000

// first physical page number handed out to list entries
`define PGWR_PPA_BASE 40'h80000

// 1: first LIST_ENTRY_CNT ATT entries come up uncompressed,
// mapped 1:1 onto the list ways
`define PGWR_PWRUP_UNCOMP 1'b1

// width of a 1-based entry index, 0 is the null pointer
`define PGWR_IDX_W 24

`endif
